/* Bender.yml */
package:
  name: retire_core

export_include_dirs:
  - include

sources:
  - files:
      - design/retire_pkg.sv
      - design/wb_if.sv
      - design/instr_decoder.sv
      - design/exec_pipe.sv
      - design/rob.sv
      - design/arch_regfile.sv
      - design/retire_core.sv
  - target: test
    files:
      - bench/retire_core_properties.sv
      - bench/retire_core_tb.sv

/* bench/retire_core_properties.sv */
// Retire slice port assertions
`timescale 1ns/1ps
`include "retire_cfg.svh"

module retire_core_properties (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     flush_i,
  input logic [`COMMIT_WIDTH-1:0] commit_valid_i,
  input logic [`COMMIT_WIDTH-1:0] commit_we_i
);

  // Count of failed assertions
  int fail_count = 0;

  // Quiet while reset holds
  flush_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !flush_i)
    else begin
      fail_count++;
      $error("flush_o asserted during reset");
    end

  // Slots retire from the bottom up
  slot_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_i[1] |-> commit_valid_i[0])
    else begin
      fail_count++;
      $error("commit slot 1 valid without slot 0");
    end

  // Register write only on a retiring slot
  we_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (commit_we_i & ~commit_valid_i) == '0)
    else begin
      fail_count++;
      $error("commit write enable without commit valid");
    end

  // Flush empties the reorder buffer, so it cannot repeat
  flush_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !flush_i)
    else begin
      fail_count++;
      $error("flush_o held for two cycles");
    end

endmodule

/* bench/retire_core_tb.sv */
// Retire slice testbench
`timescale 1ns/1ps
`include "retire_cfg.svh"

module retire_core_tb
  import retire_pkg::*;
();

  logic                                clk_i;
  logic                                rst_ni;
  logic                                instr_valid_i;
  logic [31:0]                         instr_i;
  logic [`PLEN-1:0]                    pc_i;
  logic                                instr_ready_o;
  logic [`COMMIT_WIDTH-1:0]            commit_valid_o;
  logic [`COMMIT_WIDTH-1:0][`PLEN-1:0] commit_pc_o;
  logic [`COMMIT_WIDTH-1:0]            commit_we_o;
  logic [`COMMIT_WIDTH-1:0][4:0]       commit_rd_o;
  logic [`COMMIT_WIDTH-1:0][`XLEN-1:0] commit_data_o;
  logic                                flush_o;
  logic [`PLEN-1:0]                    flush_pc_o;
  logic [4:0]                          flush_cause_o;

  // Reference model state
  logic [`XLEN-1:0] model_regs [32];
  // Expected commit is {branch, we, rd, data, pc}
  logic [70:0]      exp_q [$];
  logic [`PLEN-1:0] next_pc;
  integer           seed;
  int               errors;
  int               checks;
  int               tests_run;
  logic             flush_seen;
  logic [`PLEN-1:0] flush_pc_seen;
  logic [4:0]       flush_cause_seen;
  int               flush_left;

  retire_core UUT (.*);

  bind retire_core retire_core_properties u_props (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_o),
    .commit_valid_i (commit_valid_o),
    .commit_we_i    (commit_we_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ====================================================================
  // Model helpers
  // ====================================================================
  function automatic logic [`XLEN-1:0] sext_imm(input logic [17:0] imm);
    return {{(`XLEN-18){imm[17]}}, imm};
  endfunction

  function automatic logic [`XLEN-1:0] alu_result(input logic [3:0] op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [17:0] imm);
    case (op)
      OP_ADDI: return a + sext_imm(imm);
      OP_ANDI: return a & sext_imm(imm);
      OP_XORI: return a ^ sext_imm(imm);
      default: return '0;
    endcase
  endfunction

  function automatic logic [17:0] rand_imm();
    return 18'($random(seed));
  endfunction

  task automatic check_cond(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("FAIL @%0t: %s", $time, msg);
    end
  endtask

  // Commit and flush observer, sampled mid-cycle
  always @(negedge clk_i) begin
    logic [70:0] exp_ent;
    logic [1:0]  br_slots;
    br_slots = '0;
    if (rst_ni) begin
      for (int s = 0; s < `COMMIT_WIDTH; s++) begin
        if (commit_valid_o[s]) begin
          if (exp_q.size() == 0) begin
            check_cond(1'b0, $sformatf("unexpected commit of pc %h", commit_pc_o[s]));
          end else begin
            exp_ent     = exp_q.pop_front();
            br_slots[s] = exp_ent[70];
            check_cond(commit_pc_o[s] == exp_ent[31:0],
                       $sformatf("commit pc %h, expected %h", commit_pc_o[s], exp_ent[31:0]));
            check_cond(commit_we_o[s] == exp_ent[69],
                       $sformatf("commit we %b at pc %h", commit_we_o[s], exp_ent[31:0]));
            check_cond(!exp_ent[69] || commit_rd_o[s] == exp_ent[68:64],
                       $sformatf("commit rd %0d at pc %h", commit_rd_o[s], exp_ent[31:0]));
            check_cond(commit_data_o[s] == exp_ent[63:32],
                       $sformatf("commit data %h, expected %h at pc %h",
                                 commit_data_o[s], exp_ent[63:32], exp_ent[31:0]));
          end
        end
      end
      if (commit_valid_o == 2'b11) begin
        check_cond(br_slots != 2'b11, "two branches retired in the same cycle");
      end
      if (flush_o) begin
        flush_seen       = 1'b1;
        flush_pc_seen    = flush_pc_o;
        flush_cause_seen = flush_cause_o;
        flush_left       = exp_q.size();
      end
    end
  end

  // ====================================================================
  // Driver and waits
  // ====================================================================
  task automatic issue_instr(input logic [3:0] op, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [17:0] imm,
                             input bit squashed, output int stalls);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] res;
    logic             is_br;
    logic             we;
    bit               legal;
    bit               accepted;
    int               waited;
    a     = (rs1 == 5'd0) ? '0 : model_regs[rs1];
    is_br = (op == OP_BNEZ);
    legal = (op == OP_ADDI) || (op == OP_ANDI) || (op == OP_XORI) || is_br;
    res   = is_br ? '0 : alu_result(op, a, imm);
    we    = !is_br && (rd != 5'd0);
    if (legal && !squashed) begin
      if (we) begin
        model_regs[rd] = res;
      end
      exp_q.push_back({is_br, we, rd, res, next_pc});
    end
    instr_valid_i = 1'b1;
    instr_i       = {op, rd, rs1, imm};
    pc_i          = next_pc;
    next_pc       = next_pc + 4;
    accepted      = 1'b0;
    waited        = 0;
    stalls        = 0;
    while (!accepted && waited < 100) begin
      @(negedge clk_i);
      accepted = instr_ready_o;
      if (!accepted) begin
        stalls++;
      end
      waited++;
      @(posedge clk_i);
      #1;
    end
    instr_valid_i = 1'b0;
    if (!accepted) begin
      errors++;
      $display("Timeout: instruction at pc %h was never accepted", pc_i);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 200) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout: %0d expected commits never retired", exp_q.size());
      exp_q.delete();
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_flush();
    int waited;
    waited = 0;
    while (!flush_seen && waited < 200) begin
      @(negedge clk_i);
      waited++;
    end
    if (!flush_seen) begin
      errors++;
      $display("Timeout: no flush was raised");
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    $display("Test %0d %s done, %0d errors", tests_run, name, errors - err_start);
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic test_alu_chain();
    int e0;
    int st;
    e0 = errors;
    issue_instr(OP_ADDI, 5'd1, 5'd0, rand_imm(), 1'b0, st);
    issue_instr(OP_ANDI, 5'd2, 5'd1, rand_imm(), 1'b0, st);
    issue_instr(OP_XORI, 5'd1, 5'd2, rand_imm(), 1'b0, st);
    issue_instr(OP_ADDI, 5'd3, 5'd1, rand_imm(), 1'b0, st);
    wait_drain();
    report_test("ALU chain", e0);
  endtask

  task automatic test_back_to_back();
    int         e0;
    int         st;
    logic [3:0] op;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      op = 4'(OP_ADDI) + 4'({$random(seed)} % 3);
      issue_instr(op, 5'(11 + i), 5'(1 + i % 3), rand_imm(), 1'b0, st);
      check_cond(st == 0, "independent instruction was stalled");
    end
    wait_drain();
    report_test("back-to-back independent", e0);
  endtask

  task automatic test_hazard_stall();
    int e0;
    int st;
    e0 = errors;
    issue_instr(OP_ADDI, 5'd20, 5'd0, rand_imm(), 1'b0, st);
    issue_instr(OP_ADDI, 5'd21, 5'd20, rand_imm(), 1'b0, st);
    check_cond(st > 0, "reader of an in-flight register was not stalled");
    issue_instr(OP_XORI, 5'd22, 5'd21, rand_imm(), 1'b0, st);
    wait_drain();
    report_test("hazard stall", e0);
  endtask

  task automatic test_taken_branch();
    int               e0;
    int               st;
    logic [17:0]      imm;
    logic [`PLEN-1:0] br_pc;
    e0         = errors;
    flush_seen = 1'b0;
    // Odd immediate keeps x5 nonzero so the branch is taken
    issue_instr(OP_ADDI, 5'd5, 5'd0, rand_imm() | 18'h1, 1'b0, st);
    imm   = rand_imm();
    br_pc = next_pc;
    issue_instr(OP_BNEZ, 5'd0, 5'd5, imm, 1'b0, st);
    // Wrong-path instruction, must be squashed
    issue_instr(OP_ADDI, 5'd6, 5'd0, rand_imm(), 1'b1, st);
    wait_flush();
    check_cond(flush_pc_seen == br_pc + sext_imm(imm),
               $sformatf("flush pc %h, expected %h", flush_pc_seen, br_pc + sext_imm(imm)));
    check_cond(flush_cause_seen == 5'd0, $sformatf("flush cause %0d, expected 0", flush_cause_seen));
    check_cond(flush_left == 0, "branch had not retired when its flush was raised");
    next_pc = br_pc + sext_imm(imm);
    issue_instr(OP_ADDI, 5'd6, 5'd0, rand_imm(), 1'b0, st);
    wait_drain();
    report_test("taken BNEZ", e0);
  endtask

  task automatic test_illegal();
    int               e0;
    int               st;
    logic [`PLEN-1:0] bad_pc;
    e0         = errors;
    flush_seen = 1'b0;
    issue_instr(OP_ADDI, 5'd7, 5'd0, rand_imm(), 1'b0, st);
    bad_pc = next_pc;
    issue_instr(4'hE, 5'd8, 5'd0, rand_imm(), 1'b0, st);
    wait_flush();
    check_cond(flush_pc_seen == bad_pc,
               $sformatf("flush pc %h, expected %h", flush_pc_seen, bad_pc));
    check_cond(flush_cause_seen == `ECAUSE_ILLEGAL,
               $sformatf("flush cause %0d, expected 2", flush_cause_seen));
    check_cond(flush_left == 0, "older instruction had not retired before the fault");
    wait_drain();
    report_test("illegal opcode", e0);
  endtask

  task automatic test_not_taken_pair();
    int e0;
    int st;
    e0         = errors;
    flush_seen = 1'b0;
    issue_instr(OP_BNEZ, 5'd0, 5'd0, rand_imm(), 1'b0, st);
    issue_instr(OP_BNEZ, 5'd0, 5'd0, rand_imm(), 1'b0, st);
    wait_drain();
    check_cond(!flush_seen, "not-taken branch raised a flush");
    report_test("not-taken branch pair", e0);
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    seed          = 32'hf4f4c14d;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    flush_seen    = 1'b0;
    flush_left    = 0;
    next_pc       = 32'h0000_1000;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    check_cond(instr_ready_o && !flush_o && commit_valid_o == '0, "outputs wrong after reset");

    test_alu_chain();
    test_back_to_back();
    test_hazard_stall();
    test_taken_branch();
    test_illegal();
    test_not_taken_pair();

    errors = errors + UUT.u_props.fail_count;
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* design/arch_regfile.sv */
// Architectural register file
`timescale 1ns/1ps
`include "retire_cfg.svh"

module arch_regfile (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [`COMMIT_WIDTH-1:0]            we_i,
  input  logic [`COMMIT_WIDTH-1:0][4:0]       waddr_i,
  input  logic [`COMMIT_WIDTH-1:0][`XLEN-1:0] wdata_i,
  input  logic [4:0]                          raddr_i,
  output logic [`XLEN-1:0]                    rdata_o
);

  logic [`XLEN-1:0] regs_q [32];

  // Later slot is younger, so it overrides an earlier one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < 32; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int s = 0; s < `COMMIT_WIDTH; s++) begin
        if (we_i[s] && waddr_i[s] != 5'd0) begin
          regs_q[waddr_i[s]] <= wdata_i[s];
        end
      end
    end
  end

  // x0 is hardwired to zero
  assign rdata_o = (raddr_i == 5'd0) ? '0 : regs_q[raddr_i];

endmodule

/* design/exec_pipe.sv */
// Two-stage execute pipeline
`timescale 1ns/1ps
`include "retire_cfg.svh"

module exec_pipe
  import retire_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     issue_valid_i,
  input  dec_op_t  issue_op_i,
  input  rob_idx_t issue_idx_i,
  wb_if.source     wb
);

  logic [`XLEN-1:0] alu_res;
  logic             br_taken;
  logic [`PLEN-1:0] br_target;

  logic             s1_valid_q;
  rob_idx_t         s1_idx_q;
  logic [`XLEN-1:0] s1_data_q;
  logic             s1_exc_q;
  logic [4:0]       s1_ecause_q;
  logic             s1_mispred_q;
  logic [`PLEN-1:0] s1_target_q;

  // ===================================================================
  // Stage one compute
  // ===================================================================
  // Branches and illegal ops carry zero data
  always_comb begin
    case (issue_op_i.opcode)
      OP_ADDI: alu_res = issue_op_i.rs1_val + issue_op_i.imm;
      OP_ANDI: alu_res = issue_op_i.rs1_val & issue_op_i.imm;
      OP_XORI: alu_res = issue_op_i.rs1_val ^ issue_op_i.imm;
      default: alu_res = '0;
    endcase
  end

  // Predicted not taken, so every taken BNEZ redirects
  assign br_taken  = (issue_op_i.fu == FU_BRANCH) && (issue_op_i.rs1_val != '0);
  assign br_target = issue_op_i.pc + issue_op_i.imm[`PLEN-1:0];

  // ===================================================================
  // Pipeline registers
  // ===================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      wb.valid   <= 1'b0;
    end else if (flush_i) begin
      s1_valid_q <= 1'b0;
      wb.valid   <= 1'b0;
    end else begin
      s1_valid_q <= issue_valid_i;
      wb.valid   <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_idx_q     <= issue_idx_i;
    s1_data_q    <= alu_res;
    s1_exc_q     <= issue_op_i.illegal;
    s1_ecause_q  <= issue_op_i.illegal ? `ECAUSE_ILLEGAL : 5'd0;
    s1_mispred_q <= br_taken;
    s1_target_q  <= br_target;

    // Stage two drives the writeback bus
    wb.idx         <= s1_idx_q;
    wb.data        <= s1_data_q;
    wb.exception   <= s1_exc_q;
    wb.ecause      <= s1_ecause_q;
    wb.mispred     <= s1_mispred_q;
    wb.redirect_pc <= s1_target_q;
  end

endmodule

/* design/instr_decoder.sv */
// Instruction decoder and hazard stall
`timescale 1ns/1ps
`include "retire_cfg.svh"

module instr_decoder
  import retire_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                instr_valid_i,
  input  logic [31:0]                         instr_i,
  input  logic [`PLEN-1:0]                    pc_i,
  output logic                                instr_ready_o,
  input  logic                                rob_full_i,
  input  logic                                flush_i,
  input  logic [`COMMIT_WIDTH-1:0]            commit_valid_i,
  input  logic [`COMMIT_WIDTH-1:0][4:0]       commit_rd_i,
  input  logic [`COMMIT_WIDTH-1:0]            commit_we_i,
  output logic [4:0]                          rs1_addr_o,
  input  logic [`XLEN-1:0]                    rs1_data_i,
  output logic                                dispatch_valid_o,
  output dec_op_t                             dec_op_o
);

  // Enough to count every in-flight writer of one register
  localparam int unsigned BW = $clog2(`ROB_DEPTH + 1);

  logic [31:0][BW-1:0] busy_q, busy_d;
  logic                rs1_busy;

  // ===================================================================
  // Field decode
  // ===================================================================
  assign rs1_addr_o = instr_i[22:18];

  always_comb begin
    dec_op_o         = '0;
    dec_op_o.opcode  = opcode_e'(instr_i[31:28]);
    dec_op_o.rd      = instr_i[27:23];
    dec_op_o.rs1_val = rs1_data_i;
    dec_op_o.imm     = {{(`XLEN-18){instr_i[17]}}, instr_i[17:0]};
    dec_op_o.pc      = pc_i;
    case (dec_op_o.opcode)
      OP_ADDI, OP_ANDI, OP_XORI: begin
        dec_op_o.fu     = FU_ALU;
        dec_op_o.has_rd = 1'b1;
      end
      OP_BNEZ: begin
        dec_op_o.fu = FU_BRANCH;
      end
      default: begin
        dec_op_o.fu      = FU_NONE;
        dec_op_o.illegal = 1'b1;
      end
    endcase
  end

  // ===================================================================
  // Read-after-write stall
  // ===================================================================
  assign rs1_busy = (rs1_addr_o != 5'd0) && (busy_q[rs1_addr_o] != '0);

  assign instr_ready_o    = !rob_full_i && !flush_i && !rs1_busy;
  assign dispatch_valid_o = instr_valid_i && instr_ready_o;

  // One more writer on dispatch, one less per committing slot
  always_comb begin
    busy_d = busy_q;
    for (int r = 1; r < 32; r++) begin
      if (dispatch_valid_o && dec_op_o.has_rd && dec_op_o.rd == 5'(r)) begin
        busy_d[r] = busy_d[r] + 1'b1;
      end
      for (int s = 0; s < `COMMIT_WIDTH; s++) begin
        if (commit_valid_i[s] && commit_we_i[s] && commit_rd_i[s] == 5'(r)) begin
          busy_d[r] = busy_d[r] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else if (flush_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

endmodule

/* design/retire_core.sv */
// Retire slice top level
`timescale 1ns/1ps
`include "retire_cfg.svh"

module retire_core
  import retire_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                instr_valid_i,
  input  logic [31:0]                         instr_i,
  input  logic [`PLEN-1:0]                    pc_i,
  output logic                                instr_ready_o,
  output logic [`COMMIT_WIDTH-1:0]            commit_valid_o,
  output logic [`COMMIT_WIDTH-1:0][`PLEN-1:0] commit_pc_o,
  output logic [`COMMIT_WIDTH-1:0]            commit_we_o,
  output logic [`COMMIT_WIDTH-1:0][4:0]       commit_rd_o,
  output logic [`COMMIT_WIDTH-1:0][`XLEN-1:0] commit_data_o,
  output logic                                flush_o,
  output logic [`PLEN-1:0]                    flush_pc_o,
  output logic [4:0]                          flush_cause_o
);

  logic             rob_full;
  logic             dispatch_valid;
  dec_op_t          dec_op;
  rob_idx_t         dispatch_idx;
  logic [4:0]       rs1_addr;
  logic [`XLEN-1:0] rs1_data;

  wb_if wb ();

  instr_decoder u_decoder (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .pc_i             (pc_i),
    .instr_ready_o    (instr_ready_o),
    .rob_full_i       (rob_full),
    .flush_i          (flush_o),
    .commit_valid_i   (commit_valid_o),
    .commit_rd_i      (commit_rd_o),
    .commit_we_i      (commit_we_o),
    .rs1_addr_o       (rs1_addr),
    .rs1_data_i       (rs1_data),
    .dispatch_valid_o (dispatch_valid),
    .dec_op_o         (dec_op)
  );

  exec_pipe u_exec (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_o),
    .issue_valid_i (dispatch_valid),
    .issue_op_i    (dec_op),
    .issue_idx_i   (dispatch_idx),
    .wb            (wb.source)
  );

  rob u_rob (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dispatch_valid_i (dispatch_valid),
    .dispatch_op_i    (dec_op),
    .dispatch_idx_o   (dispatch_idx),
    .full_o           (rob_full),
    .wb               (wb.sink),
    .commit_valid_o   (commit_valid_o),
    .commit_pc_o      (commit_pc_o),
    .commit_we_o      (commit_we_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .flush_o          (flush_o),
    .flush_pc_o       (flush_pc_o),
    .flush_cause_o    (flush_cause_o)
  );

  arch_regfile u_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (commit_we_o),
    .waddr_i (commit_rd_o),
    .wdata_i (commit_data_o),
    .raddr_i (rs1_addr),
    .rdata_o (rs1_data)
  );

endmodule

/* design/retire_pkg.sv */
// Retire slice types
`include "retire_cfg.svh"

package retire_pkg;

  // Major opcode in instruction bits 31:28, all other values illegal
  typedef enum logic [3:0] {
    OP_ADDI = 4'h1,
    OP_ANDI = 4'h2,
    OP_XORI = 4'h3,
    OP_BNEZ = 4'h4
  } opcode_e;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_BRANCH,
    FU_NONE
  } fu_e;

  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

  // Decoded op handed from decoder to execute and reorder buffer
  typedef struct packed {
    fu_e              fu;
    opcode_e          opcode;
    logic [4:0]       rd;
    logic             has_rd;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] imm;
    logic [`PLEN-1:0] pc;
    logic             illegal;
  } dec_op_t;

endpackage

/* design/rob.sv */
// Reorder buffer with in-order commit
`timescale 1ns/1ps
`include "retire_cfg.svh"

module rob
  import retire_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 dispatch_valid_i,
  input  dec_op_t                              dispatch_op_i,
  output rob_idx_t                             dispatch_idx_o,
  output logic                                 full_o,
  wb_if.sink                                   wb,
  output logic [`COMMIT_WIDTH-1:0]             commit_valid_o,
  output logic [`COMMIT_WIDTH-1:0][`PLEN-1:0]  commit_pc_o,
  output logic [`COMMIT_WIDTH-1:0]             commit_we_o,
  output logic [`COMMIT_WIDTH-1:0][4:0]        commit_rd_o,
  output logic [`COMMIT_WIDTH-1:0][`XLEN-1:0]  commit_data_o,
  output logic                                 flush_o,
  output logic [`PLEN-1:0]                     flush_pc_o,
  output logic [4:0]                           flush_cause_o
);

  localparam int unsigned CNT_W = $clog2(`ROB_DEPTH + 1);
  localparam int unsigned CC_W  = $clog2(`COMMIT_WIDTH + 1);

  typedef struct packed {
    logic             complete;
    logic             exception;
    logic [4:0]       ecause;
    logic             mispred;
    logic [`PLEN-1:0] redirect_pc;
    fu_e              fu;
    logic [4:0]       rd;
    logic             has_rd;
    logic [`XLEN-1:0] data;
    logic [`PLEN-1:0] pc;
  } rob_entry_t;

  rob_entry_t rob_ram [`ROB_DEPTH];

  rob_idx_t                   head_q;
  rob_idx_t                   tail_q;
  logic [CNT_W-1:0]           count_q;
  logic                       dispatch_en;
  logic [`COMMIT_WIDTH-1:0]   br_mask;
  logic [CC_W-1:0]            commit_cnt;

  assign full_o         = (count_q == CNT_W'(`ROB_DEPTH));
  assign dispatch_idx_o = tail_q;
  assign dispatch_en    = dispatch_valid_i && !full_o;

  // ===================================================================
  // Branch commit limit
  // ===================================================================
  always_comb begin
    int unsigned br_cnt;
    rob_idx_t    idx;
    br_cnt  = 0;
    br_mask = '1;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      idx = head_q + rob_idx_t'(i);
      if (count_q > CNT_W'(i) && rob_ram[idx].fu == FU_BRANCH) begin
        if (br_cnt >= `MAX_COMMIT_BR) begin
          br_mask[i] = 1'b0;
        end
        br_cnt++;
      end
    end
  end

  // ===================================================================
  // Commit scan from the head
  // ===================================================================
  always_comb begin
    logic     stop;
    rob_idx_t idx;
    stop           = 1'b0;
    flush_o        = 1'b0;
    flush_pc_o     = '0;
    flush_cause_o  = '0;
    commit_valid_o = '0;
    commit_pc_o    = '0;
    commit_we_o    = '0;
    commit_rd_o    = '0;
    commit_data_o  = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      idx = head_q + rob_idx_t'(i);
      if (stop || count_q <= CNT_W'(i) || !br_mask[i] || !rob_ram[idx].complete) begin
        stop = 1'b1;
      end else if (rob_ram[idx].exception) begin
        // Faulting entry stays unretired
        stop          = 1'b1;
        flush_o       = 1'b1;
        flush_pc_o    = rob_ram[idx].pc;
        flush_cause_o = rob_ram[idx].ecause;
      end else begin
        commit_valid_o[i] = 1'b1;
        commit_pc_o[i]    = rob_ram[idx].pc;
        commit_rd_o[i]    = rob_ram[idx].rd;
        commit_data_o[i]  = rob_ram[idx].data;
        commit_we_o[i]    = rob_ram[idx].has_rd && (rob_ram[idx].rd != 5'd0);
        // Mispredicted branch retires, younger entries are squashed
        if (rob_ram[idx].mispred) begin
          stop          = 1'b1;
          flush_o       = 1'b1;
          flush_pc_o    = rob_ram[idx].redirect_pc;
          flush_cause_o = 5'd0;
        end
      end
    end
  end

  always_comb begin
    commit_cnt = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (commit_valid_o[i]) begin
        commit_cnt = commit_cnt + 1'b1;
      end
    end
  end

  // ===================================================================
  // Pointers and entry storage
  // ===================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_o) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + rob_idx_t'(commit_cnt);
      tail_q  <= tail_q + rob_idx_t'(dispatch_en);
      count_q <= count_q + CNT_W'(dispatch_en) - CNT_W'(commit_cnt);
    end
  end

  always_ff @(posedge clk_i) begin
    if (dispatch_en) begin
      rob_ram[tail_q].complete    <= 1'b0;
      rob_ram[tail_q].exception   <= 1'b0;
      rob_ram[tail_q].ecause      <= '0;
      rob_ram[tail_q].mispred     <= 1'b0;
      rob_ram[tail_q].redirect_pc <= '0;
      rob_ram[tail_q].fu          <= dispatch_op_i.fu;
      rob_ram[tail_q].rd          <= dispatch_op_i.rd;
      rob_ram[tail_q].has_rd      <= dispatch_op_i.has_rd;
      rob_ram[tail_q].data        <= '0;
      rob_ram[tail_q].pc          <= dispatch_op_i.pc;
    end
    // Result lands by index, never on the tail slot
    if (wb.valid) begin
      rob_ram[wb.idx].complete    <= 1'b1;
      rob_ram[wb.idx].exception   <= wb.exception;
      rob_ram[wb.idx].ecause      <= wb.ecause;
      rob_ram[wb.idx].mispred     <= wb.mispred;
      rob_ram[wb.idx].redirect_pc <= wb.redirect_pc;
      rob_ram[wb.idx].data        <= wb.data;
    end
  end

endmodule

/* design/wb_if.sv */
// Execute writeback interface
`timescale 1ns/1ps
`include "retire_cfg.svh"

interface wb_if
  import retire_pkg::*;
();

  logic             valid;
  rob_idx_t         idx;
  logic [`XLEN-1:0] data;
  logic             exception;
  logic [4:0]       ecause;
  logic             mispred;
  logic [`PLEN-1:0] redirect_pc;

  // Execute side
  modport source (
    output valid, idx, data, exception, ecause, mispred, redirect_pc
  );

  // Reorder buffer side
  modport sink (
    input valid, idx, data, exception, ecause, mispred, redirect_pc
  );

endinterface

/* filelist.f */
+incdir+include
design/retire_pkg.sv
design/wb_if.sv
design/instr_decoder.sv
design/exec_pipe.sv
design/rob.sv
design/arch_regfile.sv
design/retire_core.sv
bench/retire_core_properties.sv
bench/retire_core_tb.sv

/* include/retire_cfg.svh */
// Retire slice configuration
`ifndef RETIRE_CFG_SVH
`define RETIRE_CFG_SVH

// Datapath widths
`define XLEN 32
`define PLEN 32

// Reorder buffer sizing
`define ROB_DEPTH 16

// Retire slots and branch limit per cycle
`define COMMIT_WIDTH 2
`define MAX_COMMIT_BR 1

// Exception cause for an undefined opcode
`define ECAUSE_ILLEGAL 5'd2

`endif
